// File: verilog/soc_bus_pkg.sv
/*
 * Subsystem bus definitions
 * Target request and response words, the address views used by the
 * decoder and targets, and the area and core prefix map.
 */
package soc_bus_pkg;

  // Address seen as memory area plus byte offset
  typedef struct packed {
    logic [1:0]  area;
    logic [29:0] offset;
  } area_view_t;

  // Address seen as MMIO core plus register offset
  typedef struct packed {
    logic [1:0]  area;
    logic [5:0]  core;
    logic [23:0] reg_offset;
  } mmio_view_t;

  typedef union packed {
    area_view_t mem;
    mmio_view_t mmio;
  } bus_addr_t;

  typedef struct packed {
    logic        write;
    logic [3:0]  strb;
    bus_addr_t   addr;
    logic [31:0] wdata;
  } target_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } target_rsp_t;

  // --------------------
  // Address map
  localparam logic [1:0] ROM_AREA      = 2'd0;
  localparam logic [1:0] RAM_AREA      = 2'd1;
  localparam logic [1:0] RESERVED_AREA = 2'd2;
  localparam logic [1:0] MMIO_AREA     = 2'd3;

  localparam logic [5:0] TIMER_CORE = 6'd1;
  localparam logic [5:0] CTRL_CORE  = 6'd63;

  localparam int ROM_WORDS = 16;
  localparam int RAM_WORDS = 256;

endpackage

// File: verilog/soc_regs_pkg.sv
/*
 * Register map of the MMIO cores
 * Word indices and bit positions for the timer and the control block.
 */
package soc_regs_pkg;

  // Timer
  localparam logic [1:0] TIMER_CTRL      = 2'd0;
  localparam logic [1:0] TIMER_STATUS    = 2'd1;
  localparam logic [1:0] TIMER_PRESCALER = 2'd2;
  localparam logic [1:0] TIMER_VALUE     = 2'd3;

  localparam int TIMER_START_BIT   = 0;
  localparam int TIMER_STOP_BIT    = 1;
  localparam int TIMER_RUNNING_BIT = 0;

  // Control block
  localparam logic [1:0] CTRL_LED      = 2'd0;
  localparam logic [1:0] CTRL_GPIO     = 2'd1;
  localparam logic [1:0] CTRL_APP_MODE = 2'd2;

  localparam int LED_R_BIT    = 2;
  localparam int LED_G_BIT    = 1;
  localparam int LED_B_BIT    = 0;
  localparam int GPIO1_BIT    = 0;
  localparam int GPIO2_BIT    = 1;
  localparam int GPIO3_BIT    = 2;
  localparam int GPIO4_BIT    = 3;
  localparam int APP_MODE_BIT = 0;

endpackage

// File: verilog/bus_decoder.sv
/*
 * Bus decoder
 * Splits the Wishbone address into area and core prefixes, selects one
 * target and registers the chosen response as dat_r and ack.
 */
`timescale 1ns/1ps

module bus_decoder import soc_bus_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic [31:0] dat_r,
  output logic        ack,
  output target_req_t req,
  output logic        rom_sel,
  output logic        ram_sel,
  output logic        timer_sel,
  output logic        ctrl_sel,
  input  target_rsp_t rom_rsp,
  input  target_rsp_t ram_rsp,
  input  target_rsp_t timer_rsp,
  input  target_rsp_t ctrl_rsp
);

  bus_addr_t   addr;
  target_rsp_t muxed;

  assign addr = adr;
  assign req  = '{write: we, strb: sel, addr: addr, wdata: dat_w};

  // --------------------
  // Target select and response mux
  always_comb begin
    rom_sel   = 1'b0;
    ram_sel   = 1'b0;
    timer_sel = 1'b0;
    ctrl_sel  = 1'b0;
    muxed     = '{rdata: 32'h0, ready: 1'b0};

    // Hold off while the previous ack is out
    if (cyc && stb && !ack) begin
      case (addr.mem.area)
        ROM_AREA: begin
          rom_sel = 1'b1;
          muxed   = rom_rsp;
        end
        RAM_AREA: begin
          ram_sel = 1'b1;
          muxed   = ram_rsp;
        end
        RESERVED_AREA: muxed.ready = 1'b1;
        MMIO_AREA: begin
          case (addr.mmio.core)
            TIMER_CORE: begin
              timer_sel = 1'b1;
              muxed     = timer_rsp;
            end
            CTRL_CORE: begin
              ctrl_sel = 1'b1;
              muxed    = ctrl_rsp;
            end
            // Unknown core answers at once
            default: muxed.ready = 1'b1;
          endcase
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      dat_r <= 32'h0;
      ack   <= 1'b0;
    end else begin
      dat_r <= muxed.rdata;
      ack   <= muxed.ready;
    end
  end

  a_one_select: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({rom_sel, ram_sel, timer_sel, ctrl_sel}));

  a_single_ack: assert property (@(posedge clk) disable iff (!reset_n)
    ack |=> !ack);

endmodule

// File: verilog/boot_rom.sv
/*
 * Boot ROM
 * Firmware image read with a one-cycle response. Reads return zero
 * once the system has entered application mode.
 */
`timescale 1ns/1ps

module boot_rom import soc_bus_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        sel,
  input  target_req_t req,
  input  logic        app_mode,
  output target_rsp_t rsp
);

  logic [31:0] mem [ROM_WORDS];
  logic [$clog2(ROM_WORDS)-1:0] idx;
  logic [31:0] rdata_q;
  logic        ready_q;

  initial $readmemh("verilog/boot_rom.hex", mem);

  assign idx = req.addr.mem.offset[$clog2(ROM_WORDS)+1:2];

  // Firmware hidden from applications
  always_ff @(posedge clk) begin
    rdata_q <= app_mode ? 32'h0 : mem[idx];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

  a_ready_after_sel: assert property (@(posedge clk) disable iff (!reset_n)
    rsp.ready |-> $past(sel));

endmodule

// File: verilog/data_ram.sv
/*
 * Data RAM
 * Word memory with byte strobes and a one-cycle response.
 */
`timescale 1ns/1ps

module data_ram import soc_bus_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        sel,
  input  target_req_t req,
  output target_rsp_t rsp
);

  logic [31:0] mem [RAM_WORDS];
  logic [$clog2(RAM_WORDS)-1:0] idx;
  logic [31:0] rdata_q;
  logic        ready_q;

  // Upper offset bits are dropped so the index wraps
  assign idx = req.addr.mem.offset[$clog2(RAM_WORDS)+1:2];

  always_ff @(posedge clk) begin
    if (sel && req.write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.strb[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
    rdata_q <= mem[idx];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: verilog/timer_core.sv
/*
 * Timer core
 * Prescaled down-counter with start and stop control and a running
 * status that clears when the value reaches zero.
 */
`timescale 1ns/1ps

module timer_core import soc_bus_pkg::*, soc_regs_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        sel,
  input  target_req_t req,
  output target_rsp_t rsp
);

  logic [1:0]  reg_idx;
  logic        write_en;
  logic        running_q;
  logic [31:0] prescaler_q;
  logic [31:0] prescale_cnt_q;
  logic [31:0] value_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        ready_q;

  assign reg_idx  = req.addr.mmio.reg_offset[3:2];
  assign write_en = sel && req.write;

  // --------------------
  // Counter and register writes
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running_q      <= 1'b0;
      prescaler_q    <= 32'h0;
      prescale_cnt_q <= 32'h0;
      value_q        <= 32'h0;
    end else begin
      if (running_q) begin
        if (value_q == 32'h0) begin
          running_q <= 1'b0;
        end else if (prescale_cnt_q == prescaler_q) begin
          prescale_cnt_q <= 32'h0;
          value_q        <= value_q - 32'd1;
          if (value_q == 32'd1) running_q <= 1'b0;
        end else begin
          prescale_cnt_q <= prescale_cnt_q + 32'd1;
        end
      end

      if (write_en) begin
        case (reg_idx)
          TIMER_CTRL: begin
            if (req.wdata[TIMER_START_BIT]) begin
              running_q      <= 1'b1;
              prescale_cnt_q <= 32'h0;
            end
            // Stop wins over start
            if (req.wdata[TIMER_STOP_BIT]) running_q <= 1'b0;
          end
          TIMER_PRESCALER: prescaler_q <= req.wdata;
          TIMER_VALUE: if (!running_q) value_q <= req.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = 32'h0;
    case (reg_idx)
      TIMER_STATUS:    rdata_d[TIMER_RUNNING_BIT] = running_q;
      TIMER_PRESCALER: rdata_d = prescaler_q;
      TIMER_VALUE:     rdata_d = value_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata_d;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel;
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

  a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    running_q && (value_q == 32'h0) |=> value_q == 32'h0);

endmodule

// File: verilog/led_gpio_ctrl.sv
/*
 * LED and GPIO control block
 * LED and GPIO output registers, synchronized GPIO inputs and the
 * one-way firmware to application mode flag.
 */
`timescale 1ns/1ps

module led_gpio_ctrl import soc_bus_pkg::*, soc_regs_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        sel,
  input  target_req_t req,
  output target_rsp_t rsp,
  input  logic        gpio1,
  input  logic        gpio2,
  output logic        gpio3,
  output logic        gpio4,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b,
  output logic        app_mode
);

  logic [1:0]  reg_idx;
  logic [2:0]  led_q;
  logic [1:0]  gpio_out_q;
  logic [1:0]  gpio_meta_q;
  logic [1:0]  gpio_in_q;
  logic        app_mode_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        ready_q;

  assign reg_idx = req.addr.mmio.reg_offset[3:2];

  // Two-flop input synchronizer
  always_ff @(posedge clk) begin
    gpio_meta_q <= {gpio2, gpio1};
    gpio_in_q   <= gpio_meta_q;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_q      <= 3'b000;
      gpio_out_q <= 2'b00;
      app_mode_q <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      ready_q <= sel;
      if (sel && req.write) begin
        case (reg_idx)
          CTRL_LED: begin
            led_q <= {req.wdata[LED_R_BIT], req.wdata[LED_G_BIT], req.wdata[LED_B_BIT]};
          end
          CTRL_GPIO: gpio_out_q <= {req.wdata[GPIO4_BIT], req.wdata[GPIO3_BIT]};
          // Set only, never cleared by software
          CTRL_APP_MODE: if (req.wdata[APP_MODE_BIT]) app_mode_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = 32'h0;
    case (reg_idx)
      CTRL_LED: begin
        rdata_d[LED_R_BIT] = led_q[2];
        rdata_d[LED_G_BIT] = led_q[1];
        rdata_d[LED_B_BIT] = led_q[0];
      end
      CTRL_GPIO: begin
        rdata_d[GPIO1_BIT] = gpio_in_q[0];
        rdata_d[GPIO2_BIT] = gpio_in_q[1];
        rdata_d[GPIO3_BIT] = gpio_out_q[0];
        rdata_d[GPIO4_BIT] = gpio_out_q[1];
      end
      CTRL_APP_MODE: rdata_d[APP_MODE_BIT] = app_mode_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata_d;
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

  assign {led_r, led_g, led_b} = led_q;
  assign gpio3    = gpio_out_q[0];
  assign gpio4    = gpio_out_q[1];
  assign app_mode = app_mode_q;

endmodule

// File: verilog/application_soc.sv
/*
 * Application subsystem top level
 * Wishbone port into the decoder, boot ROM, data RAM, timer and the
 * LED and GPIO control block.
 */
`timescale 1ns/1ps

module application_soc import soc_bus_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  input  logic [3:0]  sel,
  output logic [31:0] dat_r,
  output logic        ack,
  input  logic        gpio1,
  input  logic        gpio2,
  output logic        gpio3,
  output logic        gpio4,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b
);

  target_req_t req;
  target_rsp_t rom_rsp;
  target_rsp_t ram_rsp;
  target_rsp_t timer_rsp;
  target_rsp_t ctrl_rsp;
  logic        rom_sel;
  logic        ram_sel;
  logic        timer_sel;
  logic        ctrl_sel;
  logic        app_mode;

  bus_decoder decoder_inst (
    .clk, .reset_n, .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack,
    .req, .rom_sel, .ram_sel, .timer_sel, .ctrl_sel,
    .rom_rsp, .ram_rsp, .timer_rsp, .ctrl_rsp
  );

  boot_rom rom_inst (
    .clk, .reset_n, .sel(rom_sel), .req, .app_mode, .rsp(rom_rsp)
  );

  data_ram ram_inst (
    .clk, .reset_n, .sel(ram_sel), .req, .rsp(ram_rsp)
  );

  timer_core timer_inst (
    .clk, .reset_n, .sel(timer_sel), .req, .rsp(timer_rsp)
  );

  // Control block owns the mode flag seen by the ROM
  led_gpio_ctrl ctrl_inst (
    .clk, .reset_n, .sel(ctrl_sel), .req, .rsp(ctrl_rsp),
    .gpio1, .gpio2, .gpio3, .gpio4, .led_r, .led_g, .led_b, .app_mode
  );

endmodule

// File: verification/tb_application_soc.sv
/*
 * Application subsystem testbench
 * Plays the Wishbone master and checks ROM, RAM, unmapped space,
 * timer, LED and GPIO control and the application mode lock.
 */
`timescale 1ns/1ps

module tb_application_soc import soc_bus_pkg::*, soc_regs_pkg::*; ();

  localparam int TIMER_V         = 20;
  localparam int TIMER_P         = 3;
  localparam int TIMER_WAIT      = TIMER_V * (TIMER_P + 1) + 10;
  localparam int WATCHDOG_CYCLES = 2000 + TIMER_WAIT;
  localparam int RAM_TESTS       = 12;

  logic        clk;
  logic        reset_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;
  logic        gpio1;
  logic        gpio2;
  logic        gpio3;
  logic        gpio4;
  logic        led_r;
  logic        led_g;
  logic        led_b;

  int          checks = 0;
  int          errors = 0;
  logic [31:0] lcg_state = 32'd57774;
  logic [31:0] rom_image [ROM_WORDS];
  logic [31:0] ram_model [RAM_WORDS];

  // Expected transfer latency follows the address map
  bus_addr_t   adr_view;
  logic        adr_mapped;
  logic        stb_prev = 1'b0;
  logic        stb_start;

  application_soc uut (
    .clk, .reset_n, .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack,
    .gpio1, .gpio2, .gpio3, .gpio4, .led_r, .led_g, .led_b
  );

  initial $readmemh("verilog/boot_rom.hex", rom_image);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign adr_view   = adr;
  assign adr_mapped = (adr_view.mem.area == ROM_AREA) || (adr_view.mem.area == RAM_AREA) ||
                      ((adr_view.mem.area == MMIO_AREA) &&
                       ((adr_view.mmio.core == TIMER_CORE) || (adr_view.mmio.core == CTRL_CORE)));
  assign stb_start  = stb && !stb_prev;

  always_ff @(posedge clk) begin
    stb_prev <= stb;
  end

  // --------------------
  // Ack latency
  a_mapped_latency: assert property (@(posedge clk) disable iff (!reset_n)
    $past(stb_start && adr_mapped, 2) |-> ack && !$past(ack))
    else begin
      errors++;
      $display("FAIL %0t: mapped access did not ack after two cycles", $time);
    end

  a_unmapped_latency: assert property (@(posedge clk) disable iff (!reset_n)
    $past(stb_start && !adr_mapped) |-> ack)
    else begin
      errors++;
      $display("FAIL %0t: unmapped access did not ack after one cycle", $time);
    end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] ram_addr(input int word);
    return {RAM_AREA, 30'(word * 4)};
  endfunction

  function automatic logic [31:0] core_addr(input logic [5:0] core, input logic [1:0] idx);
    return {MMIO_AREA, core, 20'h0, idx, 2'b00};
  endfunction

  // Strobed bytes come from the new word and the rest stay
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
    end
    return result;
  endfunction

  // --------------------
  // Wishbone master
  task automatic bus_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata);
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_w = wdata;
    sel   = strb;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    rdata = dat_r;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [31:0] unused_rdata;
    bus_transfer(1'b1, addr, data, strb, unused_rdata);
  endtask

  task automatic wb_read(input logic [31:0] addr, input logic [31:0] expected,
                         input string what);
    logic [31:0] rdata;
    bus_transfer(1'b0, addr, 32'h0, 4'hf, rdata);
    checks++;
    assert (rdata === expected) else begin
      errors++;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, rdata, expected);
    end
  endtask

  // Pins in order r, g, b, gpio4, gpio3
  task automatic check_pins(input logic [4:0] expected);
    checks++;
    assert ({led_r, led_g, led_b, gpio4, gpio3} === expected) else begin
      errors++;
      $display("FAIL %0t: output pins %b, expected %b", $time,
               {led_r, led_g, led_b, gpio4, gpio3}, expected);
    end
  endtask

  // --------------------
  // Test sequences
  task automatic rom_image_reads();
    for (int i = 0; i < ROM_WORDS; i++) begin
      wb_read({ROM_AREA, 30'(i * 4)}, rom_image[i], "boot ROM");
    end
  endtask

  task automatic ram_strobe_writes();
    int          word;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < RAM_TESTS; i++) begin
      word = (i * 37 + 5) % RAM_WORDS;
      data = next_random();
      wb_write(ram_addr(word), data, 4'hf);
      ram_model[word] = data;
      data = next_random();
      strb = 4'(next_random() >> 28);
      wb_write(ram_addr(word), data, strb);
      ram_model[word] = merge_bytes(ram_model[word], data, strb);
      wb_read(ram_addr(word), ram_model[word], "data RAM");
    end
    // Word index wraps at the RAM depth
    data = next_random();
    wb_write(ram_addr(RAM_WORDS + 9), data, 4'hf);
    wb_read(ram_addr(9), data, "data RAM wrap");
  endtask

  task automatic unmapped_accesses();
    wb_write({RESERVED_AREA, 30'h40}, 32'hffff_ffff, 4'hf);
    wb_read({RESERVED_AREA, 30'h40}, 32'h0, "reserved area");
    wb_read(core_addr(6'd5, 2'd0), 32'h0, "unknown core");
  endtask

  task automatic timer_countdown();
    wb_write(core_addr(TIMER_CORE, TIMER_PRESCALER), TIMER_P, 4'hf);
    wb_write(core_addr(TIMER_CORE, TIMER_VALUE), TIMER_V, 4'hf);
    wb_read(core_addr(TIMER_CORE, TIMER_PRESCALER), TIMER_P, "timer prescaler");
    wb_read(core_addr(TIMER_CORE, TIMER_VALUE), TIMER_V, "timer value");
    wb_write(core_addr(TIMER_CORE, TIMER_CTRL), 32'h1 << TIMER_START_BIT, 4'hf);
    wb_read(core_addr(TIMER_CORE, TIMER_STATUS), 32'h1 << TIMER_RUNNING_BIT, "timer running");
    repeat (TIMER_WAIT) @(posedge clk);
    wb_read(core_addr(TIMER_CORE, TIMER_VALUE), 32'h0, "timer expired value");
    wb_read(core_addr(TIMER_CORE, TIMER_STATUS), 32'h0, "timer stopped");
  endtask

  task automatic led_gpio_pins();
    wb_write(core_addr(CTRL_CORE, CTRL_LED), (32'h1 << LED_R_BIT) | (32'h1 << LED_B_BIT), 4'hf);
    check_pins(5'b101_00);
    wb_write(core_addr(CTRL_CORE, CTRL_GPIO), 32'h1 << GPIO4_BIT, 4'hf);
    check_pins(5'b101_10);
    @(posedge clk);
    #1;
    gpio1 = 1'b1;
    gpio2 = 1'b0;
    // Two sampling flops before the register sees the pins
    repeat (3) @(posedge clk);
    wb_read(core_addr(CTRL_CORE, CTRL_GPIO), (32'h1 << GPIO1_BIT) | (32'h1 << GPIO4_BIT),
            "GPIO register");
    wb_read(core_addr(CTRL_CORE, CTRL_LED), (32'h1 << LED_R_BIT) | (32'h1 << LED_B_BIT),
            "LED register");

    // Complementary pattern
    wb_write(core_addr(CTRL_CORE, CTRL_LED), 32'h1 << LED_G_BIT, 4'hf);
    wb_write(core_addr(CTRL_CORE, CTRL_GPIO), 32'h1 << GPIO3_BIT, 4'hf);
    check_pins(5'b010_01);
    @(posedge clk);
    #1;
    gpio1 = 1'b0;
    gpio2 = 1'b1;
    repeat (3) @(posedge clk);
    wb_read(core_addr(CTRL_CORE, CTRL_GPIO), (32'h1 << GPIO2_BIT) | (32'h1 << GPIO3_BIT),
            "GPIO register");
    wb_read(core_addr(CTRL_CORE, CTRL_LED), 32'h1 << LED_G_BIT, "LED register");
  endtask

  task automatic app_mode_lock();
    wb_read(core_addr(CTRL_CORE, CTRL_APP_MODE), 32'h0, "app mode at reset");
    wb_write(core_addr(CTRL_CORE, CTRL_APP_MODE), 32'h1 << APP_MODE_BIT, 4'hf);
    wb_read(core_addr(CTRL_CORE, CTRL_APP_MODE), 32'h1 << APP_MODE_BIT, "app mode set");
    wb_read({ROM_AREA, 30'h0}, 32'h0, "hidden boot ROM");
    wb_read({ROM_AREA, 30'h3c}, 32'h0, "hidden boot ROM");
    wb_write(core_addr(CTRL_CORE, CTRL_APP_MODE), 32'h0, 4'hf);
    wb_read(core_addr(CTRL_CORE, CTRL_APP_MODE), 32'h1 << APP_MODE_BIT, "app mode locked");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    reset_n = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = 32'h0;
    dat_w   = 32'h0;
    sel     = 4'h0;
    gpio1   = 1'b0;
    gpio2   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_pins(5'b000_00);

    rom_image_reads();
    ram_strobe_writes();
    unmapped_accesses();
    timer_countdown();
    led_gpio_pins();
    app_mode_lock();

    // Let the latency properties see the last transfer
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog/boot_rom.hex
// Boot ROM image: one 32-bit word per line in hex, word 0 first
10000297
00028293
30529073
00001137
ff010113
00000513
00100593
00b50633
00c62023
00460613
fec5cae3
c0000537
00100593
00b52423
0000006f
deadc0de

// File: sim.f
verilog/soc_bus_pkg.sv
verilog/soc_regs_pkg.sv
verilog/bus_decoder.sv
verilog/boot_rom.sv
verilog/data_ram.sv
verilog/timer_core.sv
verilog/led_gpio_ctrl.sv
verilog/application_soc.sv
verification/tb_application_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the application subsystem testbench with Verilator.
# The ROM image path is relative to the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_application_soc -f sim.f -o sim_app \
  && ./obj_dir/sim_app | tee /dev/stderr | grep -qx "Verification passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
